// File: tb/rs_input_vectors.txt
// columns: 31 received symbols (first is highest degree), with_error, err_count,
// then lambda coefficients 0 to 6 (coefficient 0 first), all in hex
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 00 01 00 00 00 00 00 00
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 0 00 01 00 00 00 00 00 00
1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 1F 0 00 01 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 07 00 00 00 00 00 1 01 01 05 00 00 00 00 00
0B 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 1 01 01 12 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 15 00 00 00 00 00 00 00 00 00 00 00 00 00 09 00 00 00 1 02 01 1B 0C 00 00 00 00
01 01 01 01 01 01 01 01 01 01 1E 01 01 01 01 01 01 01 01 01 02 01 01 01 01 01 01 01 01 01 05 1 03 01 1C 0F 12 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1C 00 00 00 03 00 14 0A 00 1 04 01 1B 02 12 1F 00 00
01 01 01 01 01 01 07 01 01 01 01 01 0C 01 01 01 01 01 02 01 01 01 01 01 1F 01 01 01 01 01 10 1 05 01 18 06 01 17 09 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 06 05 04 03 02 01 00 1 06 01 11 1A 1E 1B 1E 18

// File: tb.f
verilog/rs_pkg.sv
verilog/rs_syndrome.sv
verilog/rs_berlekamp.sv
verilog/rs_sequencer.sv
verilog/rs_decoder.sv
tb/rs_decoder_asserts.sv
tb/tb_rs_decoder.sv

// File: Makefile
# Verilator build for the RS decoder front end testbench

LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_rs_decoder

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_rs_decoder -o sim_rs_decoder
	./obj_dir/sim_rs_decoder | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/tb_rs_decoder.sv
/* RS decoder front end testbench */

`timescale 1ns/1ps

module tb_rs_decoder;

	import rs_pkg::*;

	localparam int clk_period = 20;
	localparam int reset_cycles = 5;
	localparam int done_timeout = 100;
	// start edge to the first cycle with done high
	localparam int block_latency = 44;
	localparam int num_vec = 10;
	// 31 symbols, with_error, err_count and seven lambda coefficients
	localparam int vec_words = 40;

	logic clk;
	logic reset;
	logic enable;
	gf_t x;
	logic done;
	logic with_error;
	cnt_t err_count;
	gf_poly_t lambda;

	logic [7:0] vec_mem [0:num_vec*vec_words-1];
	integer seed;
	int errors;
	int tests;
	int failed_tests;
	bit timed_out;
	// the first symbol of the next block is already on x with enable high
	bit chained;

	rs_decoder u_dut (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.x(x),
		.done(done),
		.with_error(with_error),
		.err_count(err_count),
		.lambda(lambda)
	);

	bind rs_decoder rs_decoder_asserts u_asserts (
		.clk(clk),
		.reset(reset),
		.syn_init(syn_init),
		.done(done),
		.err_count(err_count)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %0b, expected %0b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_poly(input string name, input gf_poly_t got, input gf_poly_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
		begin
			errors++;
			$display("error at %0t ns: done latency is %0d, expected %0d", $time, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// block driver
	// ------------------------------------------------------------------------

	// sends vector v, then waits for done and checks the results against the file
	// with hold set, enable stays high and x carries junk through the solve phase
	// a next_v of 0 or more starts that vector on the done edge with no idle cycle
	task automatic run_block(input int v, input bit hold, input int next_v);
		int base;
		int lat;
		gf_poly_t exp_poly;
		int err_before;
		base = v * vec_words;
		err_before = errors;
		for (int i = 0; i <= max_err; i++)
			exp_poly[i] = gf_t'(vec_mem[base + 33 + i]);
		// a chained block had its first symbol driven by the block before it
		if (!chained)
		begin
			@(posedge clk);
			enable <= 1'b1;
			x <= gf_t'(vec_mem[base]);
		end
		chained = 1'b0;
		for (int k = 1; k < code_len; k++)
		begin
			@(posedge clk);
			x <= gf_t'(vec_mem[base + k]);
		end
		// this edge takes the last symbol 30 edges after the start edge
		@(posedge clk);
		lat = code_len - 1;
		enable <= hold;
		x <= gf_t'($random(seed));
		forever
		begin
			@(negedge clk);
			if (done)
				break;
			@(posedge clk);
			lat++;
			// the last solve edge either drops enable or offers the next block
			if (lat == block_latency - 1)
			begin
				if (next_v >= 0)
				begin
					enable <= 1'b1;
					x <= gf_t'(vec_mem[next_v * vec_words]);
					chained = 1'b1;
				end
				else
				begin
					enable <= 1'b0;
				end
			end
			if (lat > done_timeout)
			begin
				errors++;
				timed_out = 1'b1;
				$display("vector %0d: done never came within %0d cycles", v, done_timeout);
				break;
			end
		end
		if (!timed_out)
		begin
			check_latency(lat + 1, block_latency);
			check_flag("with_error", with_error, vec_mem[base + 31][0]);
			check_count("err_count", err_count, cnt_t'(vec_mem[base + 32]));
			check_poly("lambda", lambda, exp_poly);
		end
		tests++;
		if (errors != err_before)
			failed_tests++;
		$display("test %0d vector %0d hold %0b: %s", tests, v, hold,
			(errors == err_before) ? "pass" : "fail");
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial
	begin
		int gap;
		seed = 32'h75a52a5c;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		chained = 1'b0;
		reset = 1'b1;
		enable = 1'b0;
		x = '0;
		$readmemh("tb/rs_input_vectors.txt", vec_mem);
		repeat (reset_cycles)
			@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// idle state right after reset
		check_flag("done", done, 1'b0);
		check_flag("with_error", with_error, 1'b0);
		check_count("err_count", err_count, cnt_t'(0));
		check_poly("lambda", lambda, gf_poly_t'(1));
		tests++;
		if (errors != 0)
			failed_tests++;
		$display("test %0d after reset: %s", tests, (errors == 0) ? "pass" : "fail");
		// the first pass runs in file order and every second block keeps enable high
		for (int v = 0; v < num_vec && !timed_out; v++)
			run_block(v, v[0], -1);
		// second pass in reverse with random idle gaps between blocks
		// a gap of zero starts the next block on the edge that ends done
		gap = $unsigned($random(seed)) % 4;
		for (int v = num_vec - 1; v >= 0 && !timed_out; v--)
		begin
			repeat (gap)
				@(posedge clk);
			gap = $unsigned($random(seed)) % 4;
			run_block(v, 1'b1, (v > 0 && gap == 0) ? v - 1 : -1);
		end
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: tb/rs_decoder_asserts.sv
/* decoder port assertions */

`timescale 1ns/1ps

module rs_decoder_asserts (
	input logic clk,
	input logic reset,
	input logic syn_init,
	input logic done,
	input rs_pkg::cnt_t err_count
);

	import rs_pkg::*;

	// done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done stayed high for two cycles");

	// syn_init marks the start edge, done follows 44 cycles later
	a_done_latency: assert property (@(posedge clk) disable iff (reset)
		syn_init |-> ##44 done)
		else $error("done did not arrive 44 cycles after the block start");

	// the locator degree can never exceed the correction capacity
	a_count_range: assert property (@(posedge clk) disable iff (reset)
		done |-> (err_count <= cnt_t'(max_err)))
		else $error("err_count above capacity while done is high");

endmodule

// File: verilog/rs_decoder.sv
/* Reed-Solomon decoder front end */

`timescale 1ns/1ps

module rs_decoder (
	input logic clk,
	input logic reset,
	input logic enable,
	input rs_pkg::gf_t x,
	output logic done,
	output logic with_error,
	output rs_pkg::cnt_t err_count,
	output rs_pkg::gf_poly_t lambda
);

	import rs_pkg::*;

	logic syn_init;
	logic syn_accum;
	logic berl_init;
	logic berl_step;
	cnt_t step_idx;
	gf_syn_t syndromes;

	// the sequencer owns every count and strobe
	rs_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.syn_init(syn_init),
		.syn_accum(syn_accum),
		.berl_init(berl_init),
		.berl_step(berl_step),
		.done(done),
		.step_idx(step_idx)
	);

	rs_syndrome u_syndrome (
		.clk(clk),
		.reset(reset),
		.syn_init(syn_init),
		.syn_accum(syn_accum),
		.x(x),
		.syndromes(syndromes),
		.with_error(with_error)
	);

	// syndromes are stable through the whole solve phase
	rs_berlekamp u_berlekamp (
		.clk(clk),
		.reset(reset),
		.berl_init(berl_init),
		.berl_step(berl_step),
		.step_idx(step_idx),
		.syndromes(syndromes),
		.lambda(lambda),
		.err_count(err_count)
	);

endmodule

// File: verilog/rs_sequencer.sv
/* decoder block sequencer */

`timescale 1ns/1ps

module rs_sequencer (
	input logic clk,
	input logic reset,
	input logic enable,
	output logic syn_init,
	output logic syn_accum,
	output logic berl_init,
	output logic berl_step,
	output logic done,
	output rs_pkg::cnt_t step_idx
);

	import rs_pkg::*;

	seq_state_t state;
	// symbols captured so far in this block
	cnt_t sym_cnt;
	// 0 is the solver load, 1 to num_syn are the iterations
	cnt_t iter_cnt;
	logic start;

	// ------------------------------------------------------------------------
	// strobes
	// ------------------------------------------------------------------------

	// the start edge already captures the first symbol, so the init strobe
	// must come straight from enable and not wait for a state change
	assign start = enable && ((state == st_idle) || (state == st_done));
	assign syn_init = start;
	// enable is not looked at here, a block always runs to 31 symbols
	assign syn_accum = (state == st_receive);
	assign berl_init = (state == st_solve) && (iter_cnt == '0);
	assign berl_step = (state == st_solve) && (iter_cnt != '0);
	assign step_idx = iter_cnt - cnt_t'(1);
	// st_done never lasts longer than one cycle
	assign done = (state == st_done);

	// ------------------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			sym_cnt <= '0;
			iter_cnt <= '0;
		end
		else
		begin
			case (state)
				st_idle, st_done:
				begin
					if (enable)
					begin
						state <= st_receive;
						sym_cnt <= cnt_t'(1);
					end
					else
					begin
						state <= st_idle;
					end
				end
				st_receive:
				begin
					// this edge takes the last symbol of the block
					if (sym_cnt == cnt_t'(code_len - 1))
					begin
						state <= st_solve;
						iter_cnt <= '0;
					end
					else
					begin
						sym_cnt <= sym_cnt + cnt_t'(1);
					end
				end
				st_solve:
				begin
					if (iter_cnt == cnt_t'(num_syn))
						state <= st_done;
					else
						iter_cnt <= iter_cnt + cnt_t'(1);
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// File: verilog/rs_berlekamp.sv
/* Berlekamp-Massey solver */

`timescale 1ns/1ps

module rs_berlekamp (
	input logic clk,
	input logic reset,
	input logic berl_init,
	input logic berl_step,
	input rs_pkg::cnt_t step_idx,
	input rs_pkg::gf_syn_t syndromes,
	output rs_pkg::gf_poly_t lambda,
	output rs_pkg::cnt_t err_count
);

	import rs_pkg::*;

	// correction polynomial B, already lined up so that x*B is the update term
	gf_poly_t b_poly;
	// discrepancy at the last length change
	gf_t b_prev;

	gf_t disc;
	gf_t scale;
	gf_poly_t b_shift;
	gf_poly_t lambda_next;
	logic [cnt_width:0] twice_len;
	logic length_upd;

	// ------------------------------------------------------------------------
	// iteration datapath
	// ------------------------------------------------------------------------

	// discrepancy of iteration r is the sum of lambda_i * S_(r-i)
	// syndromes[0] holds S_1, so index r-i picks S_(r-i+1) in one-based terms
	always_comb
	begin
		logic [3:0] syn_idx;
		disc = '0;
		syn_idx = '0;
		for (int i = 0; i <= max_err; i++)
		begin
			syn_idx = 4'(step_idx - cnt_t'(i));
			// terms below S_1 do not exist
			if (step_idx >= cnt_t'(i))
				disc = disc ^ gf_mul(lambda[i], syndromes[syn_idx]);
		end
	end

	assign b_shift = {b_poly[max_err-1:0], gf_t'(0)};
	// d/b, the inverse of b comes from the table
	assign scale = gf_mul(disc, gf_inv(b_prev));

	// subtraction in GF(2^m) is the same xor as addition
	always_comb
	begin
		for (int i = 0; i <= max_err; i++)
			lambda_next[i] = lambda[i] ^ gf_mul(scale, b_shift[i]);
	end

	// the register length only grows when the discrepancy is nonzero and 2L <= r
	assign twice_len = {err_count, 1'b0};
	assign length_upd = (disc != '0) && (twice_len <= {1'b0, step_idx});

	// ------------------------------------------------------------------------
	// solver registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lambda <= poly_one;
			err_count <= '0;
		end
		else if (berl_init)
		begin
			lambda <= poly_one;
			err_count <= '0;
		end
		else if (berl_step)
		begin
			lambda <= lambda_next;
			if (length_upd)
				err_count <= step_idx + cnt_t'(1) - err_count;
		end
	end

	always_ff @(posedge clk)
	begin
		if (berl_init)
		begin
			b_poly <= poly_one;
			b_prev <= gf_one;
		end
		else if (berl_step)
		begin
			if (length_upd)
			begin
				// B restarts from the locator as it was before this step
				b_poly <= lambda;
				b_prev <= disc;
			end
			else
			begin
				b_poly <= b_shift;
			end
		end
	end

endmodule

// File: verilog/rs_syndrome.sv
/* syndrome generator */

`timescale 1ns/1ps

module rs_syndrome (
	input logic clk,
	input logic reset,
	input logic syn_init,
	input logic syn_accum,
	input rs_pkg::gf_t x,
	output rs_pkg::gf_syn_t syndromes,
	output logic with_error
);

	import rs_pkg::*;

	// ------------------------------------------------------------------------
	// Horner accumulators
	// ------------------------------------------------------------------------

	// register j evaluates the received polynomial at alpha^(j+1)
	// the first symbol is the highest-degree coefficient, so each later symbol
	// scales what is already there by the root before it is added
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			syndromes <= '0;
		end
		else if (syn_init)
		begin
			// a new block overwrites whatever the previous block left behind
			for (int j = 0; j < num_syn; j++)
				syndromes[j] <= x;
		end
		else if (syn_accum)
		begin
			for (int j = 0; j < num_syn; j++)
				syndromes[j] <= gf_mul(syndromes[j], gf_alpha_pow(j + 1)) ^ x;
		end
	end

	// any nonzero syndrome means the word is not a codeword
	assign with_error = |syndromes;

endmodule

// File: verilog/rs_pkg.sv
/* GF(32) Reed-Solomon decoder definitions */

package rs_pkg;

	// ------------------------------------------------------------------------
	// field and code sizes
	// ------------------------------------------------------------------------

	localparam int sym_width = 5;
	localparam int code_len = 31;
	// twelve check symbols give twelve syndromes and twelve solver iterations
	localparam int num_syn = 12;
	localparam int max_err = 6;
	localparam int cnt_width = 5;

	typedef logic [sym_width-1:0] gf_t;
	typedef logic [num_syn-1:0][sym_width-1:0] gf_syn_t;
	// coefficient 0 is the constant term of the polynomial
	typedef logic [max_err:0][sym_width-1:0] gf_poly_t;
	typedef logic [cnt_width-1:0] cnt_t;

	typedef enum logic [1:0] {
		st_idle,
		st_receive,
		st_solve,
		st_done
	} seq_state_t;

	// x^5 folds back onto x^2 + 1 under the field polynomial x^5 + x^2 + 1
	localparam gf_t gf_prim_tail = 5'b00101;
	localparam gf_t gf_one = 5'd1;
	// the primitive element alpha is the polynomial x
	localparam gf_t gf_alpha = 5'd2;
	localparam gf_poly_t poly_one = gf_poly_t'(1);

	// ------------------------------------------------------------------------
	// field arithmetic
	// ------------------------------------------------------------------------

	// shift-and-add product, reducing each time the top bit falls out
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		gf_t prod;
		gf_t part;
		prod = '0;
		part = a;
		for (int i = 0; i < sym_width; i++)
		begin
			if (b[i])
				prod = prod ^ part;
			part = {part[sym_width-2:0], 1'b0} ^ (part[sym_width-1] ? gf_prim_tail : '0);
		end
		return prod;
	endfunction

	// inverse lookup, zero has no inverse and maps to zero
	function automatic gf_t gf_inv(gf_t a);
		gf_t inv;
		case (a)
			5'd1: inv = 5'd1;
			5'd2: inv = 5'd18;
			5'd3: inv = 5'd28;
			5'd4: inv = 5'd9;
			5'd5: inv = 5'd23;
			5'd6: inv = 5'd14;
			5'd7: inv = 5'd12;
			5'd8: inv = 5'd22;
			5'd9: inv = 5'd4;
			5'd10: inv = 5'd25;
			5'd11: inv = 5'd16;
			5'd12: inv = 5'd7;
			5'd13: inv = 5'd15;
			5'd14: inv = 5'd6;
			5'd15: inv = 5'd13;
			5'd16: inv = 5'd11;
			5'd17: inv = 5'd24;
			5'd18: inv = 5'd2;
			5'd19: inv = 5'd29;
			5'd20: inv = 5'd30;
			5'd21: inv = 5'd26;
			5'd22: inv = 5'd8;
			5'd23: inv = 5'd5;
			5'd24: inv = 5'd17;
			5'd25: inv = 5'd10;
			5'd26: inv = 5'd21;
			5'd27: inv = 5'd31;
			5'd28: inv = 5'd3;
			5'd29: inv = 5'd19;
			5'd30: inv = 5'd20;
			5'd31: inv = 5'd27;
			default: inv = '0;
		endcase
		return inv;
	endfunction

	// alpha has order 31, so the exponent is taken modulo the block length
	function automatic gf_t gf_alpha_pow(int unsigned n);
		gf_t acc;
		acc = gf_one;
		for (int unsigned i = 0; i < n % code_len; i++)
			acc = gf_mul(acc, gf_alpha);
		return acc;
	endfunction

endpackage
